// File: all.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_apb_top.sv
test/tb_uart.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_uart -o tb_uart_sim

out=$(./obj_dir/tb_uart_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'
then
	exit 0
fi
exit 1

// File: test/tb_uart.sv
`timescale 1ns/100ps
`include "uart_defs.svh"

module tb_uart;

	// ==========================================================================
	// Test sizes and run limit
	// ==========================================================================
	localparam int TX_PER_RATE  = 4;
	localparam int RX_COUNT     = 6;
	localparam int BAD_PAIRS    = 3;
	localparam int FILL_WRITES  = 18;
	// Every serial frame of the run, bad ones included
	localparam int TOTAL_FRAMES = 4 * TX_PER_RATE + RX_COUNT + 2 * BAD_PAIRS + 1 + FILL_WRITES;
	// Room for idle waits between tests
	localparam int SLACK_FRAMES = 10;
	// Worst case frame is 11 bits at 19200 baud
	localparam int TIMEOUT_CYCLES = (TOTAL_FRAMES + SLACK_FRAMES) * 11 * 16 * `UART_DIV_19200;

	logic        apb_pclk;
	logic        apb_prstn;
	logic        apb_psel;
	logic [31:0] apb_paddr;
	logic        apb_pwrite;
	logic        apb_penable;
	logic [31:0] apb_pwdata;
	logic [31:0] apb_prdata;
	logic        rs_rx;
	logic        rs_tx;
	logic        uart_irq;

	// Serial timing, shared by driver and monitor
	int          bit_cycles;
	logic        par_en;

	// Model queues and monitor output
	logic [7:0]  exp_tx[$];
	logic [7:0]  exp_rx[$];
	logic [7:0]  mon_q[$];

	logic [31:0] lfsr = 32'hb5538623;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_ok = 0;
	int          cycle_count = 0;

	uart_apb_top u_dut (
		.apb_pclk   (apb_pclk),
		.apb_prstn  (apb_prstn),
		.apb_psel   (apb_psel),
		.apb_paddr  (apb_paddr),
		.apb_pwrite (apb_pwrite),
		.apb_penable(apb_penable),
		.apb_pwdata (apb_pwdata),
		.apb_prdata (apb_prdata),
		.rs_rx      (rs_rx),
		.rs_tx      (rs_tx),
		.uart_irq   (uart_irq)
	);

	initial
	begin
		apb_pclk = 1'b0;
		forever #5 apb_pclk = ~apb_pclk;
	end

	// Hang guard
	always @(posedge apb_pclk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run went past %0d clock cycles without finishing",
				TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// ==========================================================================
	// Random numbers, model helpers, checks
	// ==========================================================================

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic random_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], random_bit()};
		return v;
	endfunction

	// Sixteen ticks per bit
	function automatic int bit_period(input logic [1:0] sel);
		int div;
		case (sel)
			2'd0: div = `UART_DIV_19200;
			2'd1: div = `UART_DIV_38400;
			2'd2: div = `UART_DIV_57600;
			default: div = `UART_DIV_115200;
		endcase
		return 16 * div;
	endfunction

	// Status word, rx_empty in bit 0 and tx_full in bit 1
	function automatic logic [31:0] expected_status(input logic tx_full);
		return {30'h0, tx_full, (exp_rx.size() == 0)};
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] want,
		input string what);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("error at %0t: %s, got %h expected %h", $time, what, got, want);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
		begin
			tests_ok++;
			$display("test %s: pass", name);
		end
		else
			$display("test %s: fail with %0d errors", name, errors - errs_before);
	endtask

	// ==========================================================================
	// APB master and serial driver
	// ==========================================================================

	// pwdata stays put one cycle past access, push samples it then
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge apb_pclk);
		apb_psel    <= 1'b1;
		apb_penable <= 1'b0;
		apb_pwrite  <= 1'b1;
		apb_paddr   <= {24'h0, addr};
		apb_pwdata  <= data;
		@(posedge apb_pclk);
		apb_penable <= 1'b1;
		@(posedge apb_pclk);
		apb_psel    <= 1'b0;
		apb_penable <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		@(posedge apb_pclk);
		apb_psel    <= 1'b1;
		apb_penable <= 1'b0;
		apb_pwrite  <= 1'b0;
		apb_paddr   <= {24'h0, addr};
		@(posedge apb_pclk);
		apb_penable <= 1'b1;
		// Mid access phase
		@(negedge apb_pclk);
		data = apb_prdata;
		@(posedge apb_pclk);
		apb_psel    <= 1'b0;
		apb_penable <= 1'b0;
	endtask

	task automatic set_config(input logic [1:0] sel, input logic parity);
		write_reg(`UART_ADDR_CTRL, {29'h0, parity, sel});
		bit_cycles = bit_period(sel);
		par_en     = parity;
	endtask

	// One frame on rs_rx, LSB first
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		@(posedge apb_pclk);
		rs_rx <= 1'b0;
		repeat (bit_cycles) @(posedge apb_pclk);
		for (int i = 0; i < 8; i++)
		begin
			rs_rx <= data[i];
			repeat (bit_cycles) @(posedge apb_pclk);
		end
		if (par_en)
		begin
			// Even parity, flipped for a broken frame
			rs_rx <= (^data) ^ bad_parity;
			repeat (bit_cycles) @(posedge apb_pclk);
		end
		rs_rx <= 1'b1;
		repeat (bit_cycles) @(posedge apb_pclk);
	endtask

	// ==========================================================================
	// Serial monitor on rs_tx
	// ==========================================================================
	initial
	begin : serial_monitor
		logic [7:0] b;
		forever
		begin
			@(negedge apb_pclk);
			if (rs_tx === 1'b0)
			begin
				// Middle of start bit
				repeat (bit_cycles / 2) @(negedge apb_pclk);
				compare({31'h0, rs_tx}, 32'h0, "tx start bit");
				for (int i = 0; i < 8; i++)
				begin
					repeat (bit_cycles) @(negedge apb_pclk);
					b[i] = rs_tx;
				end
				if (par_en)
				begin
					repeat (bit_cycles) @(negedge apb_pclk);
					compare({31'h0, rs_tx}, {31'h0, ^b}, "tx parity bit");
				end
				repeat (bit_cycles) @(negedge apb_pclk);
				compare({31'h0, rs_tx}, 32'h1, "tx stop bit");
				mon_q.push_back(b);
			end
		end
	end

	// Waits for n decoded bytes and matches them against the model
	task automatic check_tx_bytes(input int n, input string tag);
		logic [7:0] got;
		logic [7:0] want;
		while (mon_q.size() < n)
			@(negedge apb_pclk);
		for (int i = 0; i < n; i++)
		begin
			got  = mon_q.pop_front();
			want = exp_tx.pop_front();
			compare({24'h0, got}, {24'h0, want}, $sformatf("%s tx byte %0d", tag, i));
		end
	endtask

	// Pops every expected byte through the data register, then status and irq
	task automatic read_rx_bytes(input string tag);
		logic [31:0] rd;
		logic [7:0]  want;
		int          n;
		n = exp_rx.size();
		for (int i = 0; i < n; i++)
		begin
			read_reg(`UART_ADDR_DATA, rd);
			want = exp_rx.pop_front();
			compare(rd, {24'h0, want}, $sformatf("%s rx byte %0d", tag, i));
		end
		read_reg(`UART_ADDR_CTRL, rd);
		compare(rd, expected_status(1'b0), {tag, " status after draining"});
		@(negedge apb_pclk);
		compare({31'h0, uart_irq}, 32'h0, {tag, " uart_irq after draining"});
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================
	task automatic check_after_reset();
		logic [31:0] rd;
		read_reg(`UART_ADDR_CTRL, rd);
		compare(rd, expected_status(1'b0), "status after reset");
		@(negedge apb_pclk);
		compare({31'h0, uart_irq}, 32'h0, "uart_irq after reset");
		compare({31'h0, rs_tx}, 32'h1, "rs_tx after reset");
		read_reg(`UART_ADDR_DATA, rd);
		compare(rd, 32'h0, "data register after reset");
	endtask

	task automatic transmit_all_rates();
		logic [7:0] b;
		for (int sel = 0; sel < 4; sel++)
		begin
			set_config(2'(sel), random_bit());
			for (int i = 0; i < TX_PER_RATE; i++)
			begin
				b = random_byte();
				exp_tx.push_back(b);
				write_reg(`UART_ADDR_DATA, {24'h0, b});
			end
			check_tx_bytes(TX_PER_RATE, $sformatf("rate %0d", sel));
			// Rest of the stop bit before the rate changes
			repeat (bit_cycles) @(negedge apb_pclk);
		end
	endtask

	task automatic receive_bytes();
		logic [7:0] b;
		logic [1:0] sel;
		sel = {random_bit(), random_bit()};
		set_config(sel, random_bit());
		for (int i = 0; i < RX_COUNT; i++)
		begin
			b = random_byte();
			exp_rx.push_back(b);
			send_frame(b, 1'b0);
		end
		repeat (4) @(negedge apb_pclk);
		compare({31'h0, uart_irq}, 32'h1, "uart_irq with rx data waiting");
		read_rx_bytes("receive");
	endtask

	task automatic reject_bad_parity();
		logic [31:0] rd;
		logic [7:0]  b;
		set_config(2'd3, 1'b1);
		// Lone broken frame leaves nothing behind
		send_frame(random_byte(), 1'b1);
		repeat (4) @(negedge apb_pclk);
		compare({31'h0, uart_irq}, 32'h0, "uart_irq after bad parity frame");
		read_reg(`UART_ADDR_CTRL, rd);
		compare(rd, expected_status(1'b0), "status after bad parity frame");
		for (int i = 0; i < BAD_PAIRS; i++)
		begin
			send_frame(random_byte(), 1'b1);
			b = random_byte();
			exp_rx.push_back(b);
			send_frame(b, 1'b0);
		end
		repeat (4) @(negedge apb_pclk);
		compare({31'h0, uart_irq}, 32'h1, "uart_irq after good frames");
		read_rx_bytes("parity");
	endtask

	task automatic fill_tx_fifo();
		logic [31:0] rd;
		logic [7:0]  b;
		set_config(2'd0, 1'b0);
		// First byte goes straight to the shifter, next 16 fill the FIFO
		for (int i = 0; i < FILL_WRITES; i++)
		begin
			b = random_byte();
			if (i < 17)
				exp_tx.push_back(b);
			write_reg(`UART_ADDR_DATA, {24'h0, b});
		end
		read_reg(`UART_ADDR_CTRL, rd);
		compare(rd, expected_status(1'b1), "status with tx FIFO full");
		check_tx_bytes(17, "fill");
		// One more frame time, nothing further may show up
		repeat (11 * bit_cycles) @(negedge apb_pclk);
		compare(32'(mon_q.size()), 32'h0, "bytes sent beyond the first 17");
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial
	begin : main_seq
		int err_before;
		apb_prstn   <= 1'b0;
		apb_psel    <= 1'b0;
		apb_penable <= 1'b0;
		apb_pwrite  <= 1'b0;
		apb_paddr   <= 32'h0;
		apb_pwdata  <= 32'h0;
		rs_rx       <= 1'b1;
		bit_cycles = bit_period(2'd0);
		par_en     = 1'b0;
		repeat (5) @(posedge apb_pclk);
		apb_prstn <= 1'b1;
		@(posedge apb_pclk);

		err_before = errors;
		check_after_reset();
		finish_test("reset", err_before);

		err_before = errors;
		transmit_all_rates();
		finish_test("transmit", err_before);

		err_before = errors;
		receive_bytes();
		finish_test("receive", err_before);

		err_before = errors;
		reject_bad_parity();
		finish_test("parity", err_before);

		err_before = errors;
		fill_tx_fifo();
		finish_test("tx_full", err_before);

		$display("summary: %0d of %0d tests passed, %0d checks, %0d errors",
			tests_ok, tests_run, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: logic/uart_apb_top.sv
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_apb_top (
	input  logic        apb_pclk,
	input  logic        apb_prstn,
	input  logic        apb_psel,
	input  logic [31:0] apb_paddr,
	input  logic        apb_pwrite,
	input  logic        apb_penable,
	input  logic [31:0] apb_pwdata,
	output logic [31:0] apb_prdata,
	input  logic        rs_rx,
	output logic        rs_tx,
	output logic        uart_irq
);
	import uart_pkg::*;

	// ==========================================================================
	// APB side, decoded one cycle late
	// ==========================================================================
	logic       last_psel;
	logic       last_penable;
	logic       last_pwrite;
	logic [7:0] last_paddr;

	// Register strobes
	logic data_wr;
	logic data_rd;
	logic ctrl_wr;

	uart_ctrl_t   ctrl;
	uart_status_t status;

	// Block interconnect
	logic       tick;
	logic       tx_load;
	logic [7:0] tx_head;
	logic       tx_empty;
	logic       tx_full;
	logic       rx_done;
	logic [7:0] rx_dout;
	logic [7:0] rx_head;
	logic       rx_empty;

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			last_psel    <= 1'b0;
			last_penable <= 1'b0;
			last_pwrite  <= 1'b0;
			last_paddr   <= 8'h00;
		end
		else
		begin
			last_psel    <= apb_psel;
			last_penable <= apb_penable;
			last_pwrite  <= apb_pwrite;
			last_paddr   <= apb_paddr[7:0];
		end
	end

	// One-cycle strobes after the access phase
	assign data_wr = last_psel && last_penable && last_pwrite &&
		(last_paddr == `UART_ADDR_DATA);
	assign ctrl_wr = last_psel && last_penable && last_pwrite &&
		(last_paddr == `UART_ADDR_CTRL);
	assign data_rd = last_psel && last_penable && !last_pwrite &&
		(last_paddr == `UART_ADDR_DATA);

	// Control register, baud and parity
	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
			ctrl <= '0;
		else if (ctrl_wr)
			ctrl <= uart_ctrl_t'(apb_pwdata[2:0]);
	end

	assign status = '{rsvd: 6'd0, tx_full: tx_full, rx_empty: rx_empty};

	// Read mux, setup cycle already carried the address
	always_comb
	begin
		case (last_paddr)
			`UART_ADDR_DATA: apb_prdata = {24'h0, rx_head};
			`UART_ADDR_CTRL: apb_prdata = {24'h0, status};
			default: apb_prdata = 32'h0;
		endcase
	end

	// Interrupt while receive data waits
	assign uart_irq = !rx_empty;

	// ==========================================================================
	// Serial blocks
	// ==========================================================================
	uart_baud_gen u_baud (
		.apb_pclk (apb_pclk),
		.apb_prstn(apb_prstn),
		.ctrl     (ctrl),
		.tick     (tick)
	);

	// Only the low byte of a data write is sent
	uart_fifo u_tx_fifo (
		.apb_pclk (apb_pclk),
		.apb_prstn(apb_prstn),
		.push     (data_wr),
		.pop      (tx_load),
		.wdata    (apb_pwdata[7:0]),
		.rdata    (tx_head),
		.empty    (tx_empty),
		.full     (tx_full)
	);

	uart_fifo u_rx_fifo (
		.apb_pclk (apb_pclk),
		.apb_prstn(apb_prstn),
		.push     (rx_done),
		.pop      (data_rd),
		.wdata    (rx_dout),
		.rdata    (rx_head),
		.empty    (rx_empty),
		.full     ()
	);

	uart_tx u_tx (
		.apb_pclk (apb_pclk),
		.apb_prstn(apb_prstn),
		.tick     (tick),
		.ctrl     (ctrl),
		.empty    (tx_empty),
		.data     (tx_head),
		.load     (tx_load),
		.tx       (rs_tx)
	);

	uart_rx u_rx (
		.apb_pclk (apb_pclk),
		.apb_prstn(apb_prstn),
		.tick     (tick),
		.ctrl     (ctrl),
		.rx       (rs_rx),
		.done     (rx_done),
		.dout     (rx_dout)
	);

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
	input  logic                 apb_pclk,
	input  logic                 apb_prstn,
	input  logic                 tick,
	input  uart_pkg::uart_ctrl_t ctrl,
	input  logic                 rx,
	output logic                 done,
	output logic [7:0]           dout
);
	typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PARITY, S_STOP} state_t;

	// ==========================================================================
	// Input synchronizer
	// ==========================================================================
	logic rx_meta;
	logic rx_s;

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			rx_meta <= 1'b1;
			rx_s    <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
		end
	end

	// ==========================================================================
	// Frame FSM
	// ==========================================================================
	state_t     state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	// Parity result, held until stop
	logic       par_ok;
	// Mid-point of start bit
	logic       mid_start;
	// Mid-point of any later bit
	logic       mid_bit;

	assign mid_start = tick && (tick_cnt == 4'd7);
	assign mid_bit   = tick && (tick_cnt == 4'd15);
	assign dout      = shift;

	// Data bits arrive LSB first
	always_ff @(posedge apb_pclk)
	begin
		if (state == S_DATA && mid_bit)
			shift <= {rx_s, shift[7:1]};
	end

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			state    <= S_IDLE;
			tick_cnt <= 4'd0;
			bit_cnt  <= 3'd0;
			par_ok   <= 1'b1;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (tick)
				tick_cnt <= tick_cnt + 4'd1;
			case (state)
				S_IDLE:
				begin
					// Falling edge starts a frame
					tick_cnt <= 4'd0;
					if (!rx_s)
						state <= S_START;
				end
				S_START:
				begin
					// Glitch check at half a bit, then align to mid-bit
					if (mid_start)
					begin
						tick_cnt <= 4'd0;
						bit_cnt  <= 3'd0;
						par_ok   <= 1'b1;
						state    <= rx_s ? S_IDLE : S_DATA;
					end
				end
				S_DATA:
				begin
					if (mid_bit)
					begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= ctrl.parity_en ? S_PARITY : S_STOP;
					end
				end
				S_PARITY:
				begin
					// Even parity, bit equals XOR of data
					if (mid_bit)
					begin
						par_ok <= (rx_s == ^shift);
						state  <= S_STOP;
					end
				end
				default:
				begin
					// Keep only frames with good stop and parity
					if (mid_bit)
					begin
						done  <= rx_s && par_ok;
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
	input  logic                 apb_pclk,
	input  logic                 apb_prstn,
	input  logic                 tick,
	input  uart_pkg::uart_ctrl_t ctrl,
	input  logic                 empty,
	input  logic [7:0]           data,
	output logic                 load,
	output logic                 tx
);
	typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PARITY, S_STOP} state_t;

	state_t     state;
	// Ticks within current bit
	logic [3:0] tick_cnt;
	// Data bit index
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	// Even parity of captured byte
	logic       parity;
	// Last tick of a bit period
	logic       bit_end;
	logic       shift_en;

	// Idle with data waiting, grab head and pop
	assign load     = (state == S_IDLE) && !empty;
	assign bit_end  = tick && (tick_cnt == 4'd15);
	assign shift_en = bit_end && ((state == S_START) ||
		((state == S_DATA) && (bit_cnt != 3'd7)));

	// Payload, LSB goes out first
	always_ff @(posedge apb_pclk)
	begin
		if (load)
		begin
			shift  <= data;
			parity <= ^data;
		end
		else if (shift_en)
			shift <= shift >> 1;
	end

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			state    <= S_IDLE;
			tick_cnt <= 4'd0;
			bit_cnt  <= 3'd0;
			tx       <= 1'b1;
		end
		else
		begin
			if (tick)
				tick_cnt <= tick_cnt + 4'd1;
			case (state)
				S_IDLE:
				begin
					// Start bit driven right away
					tick_cnt <= 4'd0;
					if (load)
					begin
						state <= S_START;
						tx    <= 1'b0;
					end
				end
				S_START:
				begin
					if (bit_end)
					begin
						state   <= S_DATA;
						bit_cnt <= 3'd0;
						tx      <= shift[0];
					end
				end
				S_DATA:
				begin
					if (bit_end && bit_cnt == 3'd7)
					begin
						// Optional parity slot before stop
						state <= ctrl.parity_en ? S_PARITY : S_STOP;
						tx    <= ctrl.parity_en ? parity : 1'b1;
					end
					else if (bit_end)
					begin
						bit_cnt <= bit_cnt + 3'd1;
						tx      <= shift[0];
					end
				end
				S_PARITY:
				begin
					if (bit_end)
					begin
						state <= S_STOP;
						tx    <= 1'b1;
					end
				end
				default:
				begin
					// Stop bit, then back to idle
					if (bit_end)
						state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/uart_fifo.sv
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_fifo (
	input  logic       apb_pclk,
	input  logic       apb_prstn,
	input  logic       push,
	input  logic       pop,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       empty,
	output logic       full
);
	localparam int AW    = `UART_FIFO_AWIDTH;
	localparam int DEPTH = 1 << AW;

	// Storage array
	logic [7:0] mem [DEPTH];

	// Pointers carry one extra wrap bit
	logic [AW:0] wptr;
	logic [AW:0] rptr;

	// Guarded strobes
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Wrap bits tell full from empty at equal index
	assign empty = (wptr == rptr);
	assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

	// Head always visible on rdata
	assign rdata = mem[rptr[AW-1:0]];

	// Reset clears the array so early reads give zero
	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= 8'h00;
		end
		else if (do_push)
		begin
			mem[wptr[AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else
		begin
			// Push and pop may both land in one cycle
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
				rptr <= rptr + 1'b1;
		end
	end

endmodule

// File: logic/uart_baud_gen.sv
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_baud_gen (
	input  logic                 apb_pclk,
	input  logic                 apb_prstn,
	input  uart_pkg::uart_ctrl_t ctrl,
	output logic                 tick
);
	// Divisor picked by baud select
	logic [7:0] div;
	// Free-running oversample counter
	logic [7:0] cnt;
	// Previous baud select, for restart on change
	logic [1:0] sel_q;

	always_comb
	begin
		case (ctrl.baud_sel)
			2'd0: div = 8'(`UART_DIV_19200);
			2'd1: div = 8'(`UART_DIV_38400);
			2'd2: div = 8'(`UART_DIV_57600);
			default: div = 8'(`UART_DIV_115200);
		endcase
	end

	always_ff @(posedge apb_pclk or negedge apb_prstn)
	begin
		if (!apb_prstn)
		begin
			cnt   <= 8'd0;
			sel_q <= 2'd0;
			tick  <= 1'b0;
		end
		else
		begin
			sel_q <= ctrl.baud_sel;
			// New rate, start counting from scratch
			if (sel_q != ctrl.baud_sel)
			begin
				cnt  <= 8'd0;
				tick <= 1'b0;
			end
			else if (cnt == div - 8'd1)
			begin
				cnt  <= 8'd0;
				tick <= 1'b1;
			end
			else
			begin
				cnt  <= cnt + 8'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

// File: logic/uart_pkg.sv
// ==========================================================================
// UART register types
// ==========================================================================

package uart_pkg;

	// Control register, write side of offset 0x04
	// Bit 2 parity enable, bits 1:0 baud select
	typedef struct packed
	{
		logic       parity_en;
		// 0 -> 19200, 1 -> 38400, 2 -> 57600, 3 -> 115200
		logic [1:0] baud_sel;
	} uart_ctrl_t;

	// Status register, read side of offset 0x04
	typedef struct packed
	{
		// Always zero
		logic [5:0] rsvd;
		// Transmit FIFO cannot take another byte
		logic       tx_full;
		// Nothing waiting in receive FIFO
		logic       rx_empty;
	} uart_status_t;

endpackage

// File: logic/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// ==========================================================================
// UART peripheral constants
// ==========================================================================

// APB clock in Hz
`define UART_CLK_FREQ 50_000_000

// Clock cycles per 16x oversample tick, CLK / (16 * baud), rounded
`define UART_DIV_19200  163
`define UART_DIV_38400  81
`define UART_DIV_57600  54
`define UART_DIV_115200 27

// 16-entry FIFOs
`define UART_FIFO_AWIDTH 4

// Register offsets, low address byte
`define UART_ADDR_DATA 8'h00
`define UART_ADDR_CTRL 8'h04

`endif
